//--- frame_timer.sv
`timescale 1ns/100ps

module frame_timer #(
    parameter int FRAMES_PER_SEC = 60
) (
    input  logic clock,
    input  logic reset,
    input  logic vsync,
    input  logic timer_go,
    output logic second_tick
);

    localparam int CW = $clog2(FRAMES_PER_SEC + 1);
    localparam logic [CW-1:0] LAST_FRAME = CW'(FRAMES_PER_SEC - 1);

    logic          vsync_meta;
    logic          vsync_sync;
    logic          vsync_last;
    logic          frame_tick;
    logic [CW-1:0] frame_count;

    // vsync is asynchronous, two flops before anything looks at it
    always_ff @(posedge clock) begin
        if (reset) begin
            vsync_meta <= 1'b0;
            vsync_sync <= 1'b0;
            vsync_last <= 1'b0;
            frame_tick <= 1'b0;
            frame_count <= '0;
        end else begin
            vsync_meta <= vsync;
            vsync_sync <= vsync_meta;
            vsync_last <= vsync_sync;
            frame_tick <= vsync_last & ~vsync_sync; // one pulse per falling edge
            if (frame_tick && timer_go) begin
                frame_count <= (frame_count == LAST_FRAME) ? '0 : frame_count + 1'b1;
            end
        end
    end

    // the last frame of each second carries the second tick with it
    assign second_tick = frame_tick && timer_go && (frame_count == LAST_FRAME);

endmodule

//--- game_event_pkg.sv
package game_event_pkg;

    localparam int RECIPE_BITS = 2;

    // plate code on a serving window
    // bit 3 burnt, bit 2 plated, low bits carry the recipe
    localparam int PLATE_BURNT_BIT = 3;
    localparam int PLATE_PLATED_BIT = 2;

    typedef logic [3:0] plate_t;
    typedef logic [RECIPE_BITS-1:0] recipe_t;

    // one removal from the order queue
    // the top bit picks the view, 1 for a serve and 0 for an expiry
    typedef union packed {
        struct packed {
            logic                  kind;
            logic                  window;    // serving window that took the order
            game_rules_pkg::time_t time_left; // seconds left when it was served
            logic [1:0]            spare;
        } served;
        struct packed {
            logic       kind;
            logic [1:0] slot;   // queue slot the order expired in
            recipe_t    recipe;
            logic [3:0] spare;
        } missed;
    } outcome_u;

endpackage

//--- game_rules_pkg.sv
package game_rules_pkg;

    // queue depth and order lifetime
    localparam int SLOT_COUNT = 4;
    localparam int ORDER_SECONDS = 30;

    // a serve earns base points plus a bonus picked by the seconds left on the order
    localparam int SERVE_POINTS = 20;
    localparam int BONUS_HIGH = 6;
    localparam int BONUS_MID = 4;
    localparam int BONUS_LOW = 2;

    // bonus tiers apply strictly above these second counts
    localparam int BONUS_HIGH_ABOVE = 15;
    localparam int BONUS_MID_ABOVE = 10;
    localparam int BONUS_LOW_ABOVE = 5;

    localparam int MISS_PENALTY = 10; // taken only when the total can cover it

    typedef logic [4:0] time_t;   // seconds left on an order
    typedef logic [9:0] points_t; // running score, saturates at all ones

endpackage

//--- kitchen_orders.f
game_rules_pkg.sv
game_event_pkg.sv
frame_timer.sv
order_spawner.sv
order_queue.sv
score_keeper.sv
kitchen_orders_top.sv
kitchen_orders_sva.sv
tb_kitchen_orders.sv

//--- kitchen_orders_sva.sv
`timescale 1ns/100ps

module kitchen_orders_sva (
    input logic                         clock,
    input logic                         reset,
    input logic [3:0]                   orders,
    input game_event_pkg::plate_t [1:0] check_spaces,
    input logic                         clear_space0,
    input logic                         clear_space1,
    input game_rules_pkg::points_t      point_total,
    input logic                         spawn_valid,
    input logic                         spawn_ready,
    input game_event_pkg::recipe_t      spawn_recipe,
    input logic                         outcome_valid,
    input logic                         outcome_ready,
    input game_event_pkg::outcome_u     outcome_word
);

    // the queue fills from bit 0 and never holds more than four orders
    occupancy_packed: assert property (@(posedge clock) disable iff (reset)
        orders inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111})
        else $error("orders is not a packed occupancy pattern");

    clear0_one_cycle: assert property (@(posedge clock) disable iff (reset)
        clear_space0 |=> !clear_space0)
        else $error("clear_space0 held longer than one cycle");

    clear1_one_cycle: assert property (@(posedge clock) disable iff (reset)
        clear_space1 |=> !clear_space1)
        else $error("clear_space1 held longer than one cycle");

    one_clear_at_a_time: assert property (@(posedge clock) disable iff (reset)
        !(clear_space0 && clear_space1))
        else $error("both windows cleared in the same cycle");

    // a clear follows the edge that saw a plated plate that was not burnt
    clear0_needs_plate: assert property (@(posedge clock) disable iff (reset)
        clear_space0 |->
            $past(check_spaces[0][game_event_pkg::PLATE_PLATED_BIT]
                  && !check_spaces[0][game_event_pkg::PLATE_BURNT_BIT]))
        else $error("window 0 cleared without a good plate");

    clear1_needs_plate: assert property (@(posedge clock) disable iff (reset)
        clear_space1 |->
            $past(check_spaces[1][game_event_pkg::PLATE_PLATED_BIT]
                  && !check_spaces[1][game_event_pkg::PLATE_BURNT_BIT]))
        else $error("window 1 cleared without a good plate");

    spawn_held: assert property (@(posedge clock) disable iff (reset)
        spawn_valid && !spawn_ready |=> spawn_valid && $stable(spawn_recipe))
        else $error("spawn offer dropped or changed before transfer");

    // stage 2 adds the serve two cycles after the transfer
    serve_raises_total: assert property (@(posedge clock) disable iff (reset)
        outcome_valid && outcome_ready && outcome_word.served.kind |->
            ##2 (point_total > $past(point_total, 2) || point_total == '1))
        else $error("a served outcome did not raise point_total two cycles later");

    // the oldest order sits in slot 0 and always runs out first
    miss_from_front: assert property (@(posedge clock) disable iff (reset)
        outcome_valid && !outcome_word.missed.kind |-> outcome_word.missed.slot == 2'd0)
        else $error("an expiry was reported for a slot other than slot 0");

    // a miss is the only way down, and it always costs the full penalty
    drop_is_penalty: assert property (@(posedge clock) disable iff (reset)
        point_total < $past(point_total) |->
            ($past(point_total) - point_total) == 10'(game_rules_pkg::MISS_PENALTY))
        else $error("point_total dropped by something other than the penalty");

endmodule

bind kitchen_orders_top kitchen_orders_sva sva_inst (
    .clock        (clock),
    .reset        (reset),
    .orders       (orders),
    .check_spaces (check_spaces),
    .clear_space0 (clear_space0),
    .clear_space1 (clear_space1),
    .point_total  (point_total),
    .spawn_valid  (spawn_valid),
    .spawn_ready  (spawn_ready),
    .spawn_recipe (spawn_recipe),
    .outcome_valid(outcome_valid),
    .outcome_ready(outcome_ready),
    .outcome_word (outcome_word)
);

//--- kitchen_orders_top.sv
`timescale 1ns/100ps

module kitchen_orders_top #(
    parameter int FRAMES_PER_SEC = 60,
    parameter int SECONDS_PER_ORDER = 20
) (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  logic                                                    vsync,
    input  logic                                                    timer_go,
    input  game_event_pkg::plate_t [1:0]                            check_spaces,
    output logic                                                    clear_space0,
    output logic                                                    clear_space1,
    output game_rules_pkg::points_t                                 point_total,
    output logic [game_rules_pkg::SLOT_COUNT-1:0]                   orders,
    output game_rules_pkg::time_t [game_rules_pkg::SLOT_COUNT-1:0] order_times
);

    logic                     second_tick;
    logic                     spawn_valid;
    logic                     spawn_ready;
    game_event_pkg::recipe_t  spawn_recipe;
    logic                     outcome_valid;
    logic                     outcome_ready;
    game_event_pkg::outcome_u outcome_word;

    frame_timer #(
        .FRAMES_PER_SEC(FRAMES_PER_SEC)
    ) frame_timer_inst (
        .clock      (clock),
        .reset      (reset),
        .vsync      (vsync),
        .timer_go   (timer_go),
        .second_tick(second_tick)
    );

    order_spawner #(
        .SECONDS_PER_ORDER(SECONDS_PER_ORDER)
    ) order_spawner_inst (
        .clock       (clock),
        .reset       (reset),
        .second_tick (second_tick),
        .timer_go    (timer_go),
        .spawn_valid (spawn_valid),
        .spawn_ready (spawn_ready),
        .spawn_recipe(spawn_recipe)
    );

    // the queue sits between the spawner and the score, both sides handshake
    order_queue order_queue_inst (
        .clock        (clock),
        .reset        (reset),
        .second_tick  (second_tick),
        .timer_go     (timer_go),
        .check_spaces (check_spaces),
        .spawn_valid  (spawn_valid),
        .spawn_ready  (spawn_ready),
        .spawn_recipe (spawn_recipe),
        .clear_space0 (clear_space0),
        .clear_space1 (clear_space1),
        .orders       (orders),
        .order_times  (order_times),
        .outcome_valid(outcome_valid),
        .outcome_ready(outcome_ready),
        .outcome_word (outcome_word)
    );

    score_keeper score_keeper_inst (
        .clock        (clock),
        .reset        (reset),
        .outcome_valid(outcome_valid),
        .outcome_ready(outcome_ready),
        .outcome_word (outcome_word),
        .point_total  (point_total)
    );

endmodule

//--- order_queue.sv
`timescale 1ns/100ps

module order_queue (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  logic                                                    second_tick,
    input  logic                                                    timer_go,
    input  game_event_pkg::plate_t [1:0]                            check_spaces,
    input  logic                                                    spawn_valid,
    output logic                                                    spawn_ready,
    input  game_event_pkg::recipe_t                                 spawn_recipe,
    output logic                                                    clear_space0,
    output logic                                                    clear_space1,
    output logic [game_rules_pkg::SLOT_COUNT-1:0]                   orders,
    output game_rules_pkg::time_t [game_rules_pkg::SLOT_COUNT-1:0] order_times,
    output logic                                                    outcome_valid,
    input  logic                                                    outcome_ready,
    output game_event_pkg::outcome_u                                outcome_word
);

    localparam int SLOTS = game_rules_pkg::SLOT_COUNT;
    localparam game_rules_pkg::time_t FULL_TIME =
        game_rules_pkg::time_t'(game_rules_pkg::ORDER_SECONDS);

    game_event_pkg::recipe_t                  slot_recipe [SLOTS];
    game_rules_pkg::time_t [SLOTS-1:0]       aged_times;
    game_event_pkg::outcome_u                 rm_word;
    logic [1:0]                               serve_hit;
    logic [SLOTS-1:0]                         expired;
    logic                                     removal_cand;
    logic                                     rm_served;
    logic                                     rm_window;
    logic [1:0]                               rm_slot;
    logic [1:0]                               free_slot;
    logic                                     take;
    logic                                     spawn_take;

    // window k only ever looks at slot k
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            serve_hit[k] = orders[k]
                && check_spaces[k][game_event_pkg::PLATE_PLATED_BIT]
                && !check_spaces[k][game_event_pkg::PLATE_BURNT_BIT]
                && (check_spaces[k][game_event_pkg::RECIPE_BITS-1:0] == slot_recipe[k]);
        end
        for (int i = 0; i < SLOTS; i++) begin
            expired[i] = orders[i] && (order_times[i] == '0);
        end
    end

    // serves beat expiries, lower window and lower slot first
    always_comb begin
        rm_served = 1'b0;
        rm_window = 1'b0;
        rm_slot = '0;
        removal_cand = 1'b1;
        if (serve_hit[0]) begin
            rm_served = 1'b1;
        end else if (serve_hit[1]) begin
            rm_served = 1'b1;
            rm_window = 1'b1;
            rm_slot = 2'd1;
        end else if (expired[0]) begin
            rm_slot = 2'd0;
        end else if (expired[1]) begin
            rm_slot = 2'd1;
        end else if (expired[2]) begin
            rm_slot = 2'd2;
        end else if (expired[3]) begin
            rm_slot = 2'd3;
        end else begin
            removal_cand = 1'b0;
        end
    end

    always_comb begin
        rm_word = '0;
        if (rm_served) begin
            rm_word.served.kind = 1'b1;
            rm_word.served.window = rm_window;
            rm_word.served.time_left = order_times[rm_slot];
        end else begin
            rm_word.missed.kind = 1'b0;
            rm_word.missed.slot = rm_slot;
            rm_word.missed.recipe = slot_recipe[rm_slot];
        end
    end

    // occupancy fills from bit 0, so the first empty bit is where a new order lands
    always_comb begin
        free_slot = '0;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (!orders[i]) free_slot = 2'(i);
        end
        for (int i = 0; i < SLOTS; i++) begin
            aged_times[i] = order_times[i];
            if (second_tick && orders[i] && (order_times[i] != '0)) begin
                aged_times[i] = order_times[i] - 1'b1;
            end
        end
    end

    assign take = timer_go && removal_cand && !outcome_valid;
    assign spawn_ready = timer_go && !orders[SLOTS-1] && !removal_cand;
    assign spawn_take = spawn_valid && spawn_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            orders <= '0;
            for (int i = 0; i < SLOTS; i++) begin
                order_times[i] <= FULL_TIME;
            end
            clear_space0 <= 1'b0;
            clear_space1 <= 1'b0;
            outcome_valid <= 1'b0;
        end else begin
            clear_space0 <= take && rm_served && !rm_window;
            clear_space1 <= take && rm_served && rm_window;
            order_times <= aged_times; // countdown runs even while the outcome waits
            if (take) begin
                orders <= orders >> 1;
                for (int i = 0; i < SLOTS - 1; i++) begin
                    if (i >= rm_slot) order_times[i] <= aged_times[i+1];
                end
                order_times[SLOTS-1] <= FULL_TIME;
                outcome_valid <= 1'b1;
            end else begin
                if (spawn_take) begin
                    orders <= {orders[SLOTS-2:0], 1'b1};
                    order_times[free_slot] <= FULL_TIME;
                end
                if (outcome_valid && outcome_ready) outcome_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            for (int i = 0; i < SLOTS - 1; i++) begin
                if (i >= rm_slot) slot_recipe[i] <= slot_recipe[i+1];
            end
            outcome_word <= rm_word;
        end else if (spawn_take) begin
            slot_recipe[free_slot] <= spawn_recipe;
        end
    end

endmodule

//--- order_spawner.sv
`timescale 1ns/100ps

module order_spawner #(
    parameter int SECONDS_PER_ORDER = 20
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    second_tick,
    input  logic                    timer_go,
    output logic                    spawn_valid,
    input  logic                    spawn_ready,
    output game_event_pkg::recipe_t spawn_recipe
);

    localparam int CW = $clog2(SECONDS_PER_ORDER + 1);
    localparam logic [CW-1:0] LAST_SECOND = CW'(SECONDS_PER_ORDER - 1);

    logic [CW-1:0] second_count;
    logic          period_done;
    logic          spawn_taken;

    assign period_done = second_tick && timer_go && (second_count == LAST_SECOND);
    assign spawn_taken = spawn_valid && spawn_ready;

    // the count starts at its last value so the first tick after start already offers
    always_ff @(posedge clock) begin
        if (reset) begin
            second_count <= LAST_SECOND;
            spawn_valid <= 1'b0;
            spawn_recipe <= '0;
        end else begin
            if (second_tick && timer_go) begin
                second_count <= period_done ? '0 : second_count + 1'b1;
            end

            // a period that ends while an offer still waits adds nothing new
            if (period_done) begin
                spawn_valid <= 1'b1;
            end else if (spawn_taken) begin
                spawn_valid <= 1'b0;
            end

            if (spawn_taken) begin
                spawn_recipe <= spawn_recipe + 1'b1; // recipes come round in turn
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build with Verilator and run, the result is read from the simulation output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_kitchen_orders \
    -f kitchen_orders.f \
    -o sim_kitchen_orders \
    && ./obj_dir/sim_kitchen_orders | tee /dev/stderr | grep -q "^No errors$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- score_keeper.sv
`timescale 1ns/100ps

module score_keeper (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     outcome_valid,
    output logic                     outcome_ready,
    input  game_event_pkg::outcome_u outcome_word,
    output game_rules_pkg::points_t  point_total
);

    logic                    s1_valid;
    logic                    s1_add;
    game_rules_pkg::points_t s1_amount;
    logic                    decoded_add;
    game_rules_pkg::points_t decoded_amount;
    game_rules_pkg::points_t next_total;
    logic [10:0]             raised;
    logic                    accept;

    assign outcome_ready = !s1_valid; // one event in flight at a time
    assign accept = outcome_valid && outcome_ready;

    // served words carry the seconds left, missed words only cost the penalty
    always_comb begin
        if (outcome_word.served.kind) begin
            decoded_add = 1'b1;
            if (outcome_word.served.time_left > game_rules_pkg::BONUS_HIGH_ABOVE) begin
                decoded_amount = game_rules_pkg::points_t'(
                    game_rules_pkg::SERVE_POINTS + game_rules_pkg::BONUS_HIGH);
            end else if (outcome_word.served.time_left > game_rules_pkg::BONUS_MID_ABOVE) begin
                decoded_amount = game_rules_pkg::points_t'(
                    game_rules_pkg::SERVE_POINTS + game_rules_pkg::BONUS_MID);
            end else if (outcome_word.served.time_left > game_rules_pkg::BONUS_LOW_ABOVE) begin
                decoded_amount = game_rules_pkg::points_t'(
                    game_rules_pkg::SERVE_POINTS + game_rules_pkg::BONUS_LOW);
            end else begin
                decoded_amount = game_rules_pkg::points_t'(game_rules_pkg::SERVE_POINTS);
            end
        end else begin
            decoded_add = 1'b0;
            decoded_amount = game_rules_pkg::points_t'(game_rules_pkg::MISS_PENALTY);
        end
    end

    always_comb begin
        raised = {1'b0, point_total} + {1'b0, s1_amount};
        if (s1_add) begin
            next_total = raised[10] ? '1 : raised[9:0]; // clamp at 1023
        end else if (point_total >= s1_amount) begin
            next_total = point_total - s1_amount;
        end else begin
            next_total = point_total; // a miss never pushes the score below zero
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid <= 1'b0;
            point_total <= '0;
        end else begin
            s1_valid <= accept;
            if (s1_valid) point_total <= next_total;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            s1_add <= decoded_add;
            s1_amount <= decoded_amount;
        end
    end

endmodule

//--- tb_kitchen_orders.sv
`timescale 1ns/100ps

module tb_kitchen_orders;

    localparam int CYCLE_LIMIT = 12000; // well above the test length at 32 cycles per second

    logic                           clock;
    logic                           reset;
    logic                           vsync;
    logic                           timer_go;
    game_event_pkg::plate_t [1:0]   check_spaces;
    logic                           clear_space0;
    logic                           clear_space1;
    game_rules_pkg::points_t        point_total;
    logic [3:0]                     orders;
    game_rules_pkg::time_t [3:0]    order_times;

    int                             expected_total;
    int                             settle;
    int                             cycle_count;
    int                             next_recipe;
    int                             serve_count;
    int                             miss_count;
    int                             model_recipes[$];
    logic [3:0]                     prev_orders;
    game_rules_pkg::time_t [3:0]    prev_times;
    game_event_pkg::plate_t [1:0]   prev_plates;

    kitchen_orders_top #(
        .FRAMES_PER_SEC(4),
        .SECONDS_PER_ORDER(3)
    ) kitchen_orders_top_inst (
        .clock       (clock),
        .reset       (reset),
        .vsync       (vsync),
        .timer_go    (timer_go),
        .check_spaces(check_spaces),
        .clear_space0(clear_space0),
        .clear_space1(clear_space1),
        .point_total (point_total),
        .orders      (orders),
        .order_times (order_times)
    );

    task automatic flag_mismatch(input string name, input int expected, input int actual);
        $display("** Error %s expected %h actual %h", name, expected, actual);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    function automatic int serve_value(input int seconds_left);
        if (seconds_left > 15) return game_rules_pkg::SERVE_POINTS + game_rules_pkg::BONUS_HIGH;
        if (seconds_left > 10) return game_rules_pkg::SERVE_POINTS + game_rules_pkg::BONUS_MID;
        if (seconds_left > 5) return game_rules_pkg::SERVE_POINTS + game_rules_pkg::BONUS_LOW;
        return game_rules_pkg::SERVE_POINTS;
    endfunction

    // a plated plate of the order's recipe now and then, otherwise any code at all
    task automatic pick_plates(input int match_odds);
        game_event_pkg::plate_t plate;
        for (int k = 0; k < 2; k++) begin
            if (($urandom % match_odds) == 0 && model_recipes.size() > k) begin
                plate = {2'b01, 2'(model_recipes[k])};
            end else begin
                plate = 4'($urandom % 16);
            end
            check_spaces[k] = plate;
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // vsync falls once every 8 cycles
    initial begin
        vsync = 1'b1;
        forever begin
            repeat (4) @(posedge clock);
            #1 vsync = ~vsync;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $fatal(1);
        end
    end

    // the score model watches the queue on the falling edge, where everything is settled
    always @(negedge clock) begin : score_model
        int k;
        int removed_slot;
        if (reset) begin
            model_recipes.delete();
            next_recipe = 0;
            expected_total = 0;
            settle = 0;
        end else begin
            if ($countones(orders) > $countones(prev_orders)) begin
                model_recipes.push_back(next_recipe);
                next_recipe = (next_recipe + 1) % 4;
            end else if ($countones(orders) < $countones(prev_orders)) begin
                if (clear_space0 || clear_space1) begin
                    k = clear_space1 ? 1 : 0;
                    // plates seen on the edge that did the serve
                    assert (model_recipes.size() > k && prev_plates[k][2] && !prev_plates[k][3]
                            && int'(prev_plates[k][1:0]) == model_recipes[k])
                        else abort_run("a window cleared without a matching plated plate");
                    if (k == 1) begin
                        assert (!(prev_plates[0][2] && !prev_plates[0][3]
                                  && int'(prev_plates[0][1:0]) == model_recipes[0]))
                            else abort_run("window 1 was served while window 0 also matched");
                    end
                    expected_total += serve_value(int'(prev_times[k]));
                    if (expected_total > 1023) expected_total = 1023;
                    model_recipes.delete(k);
                    serve_count++;
                end else begin
                    removed_slot = -1;
                    for (int i = 0; i < 4; i++) begin
                        if (removed_slot < 0 && prev_orders[i] && prev_times[i] == 0) begin
                            removed_slot = i;
                        end
                    end
                    assert (removed_slot >= 0)
                        else abort_run("an order left the queue with time still on it");
                    if (expected_total >= game_rules_pkg::MISS_PENALTY) begin
                        expected_total -= game_rules_pkg::MISS_PENALTY;
                    end
                    model_recipes.delete(removed_slot);
                    miss_count++;
                end
                settle = 0;
            end else if (settle < 100) begin
                settle++;
            end
            assert (!(clear_space0 || clear_space1) || $countones(orders) < $countones(prev_orders))
                else abort_run("a clear pulsed but no order was removed");
            if (settle >= 2) begin
                assert (int'(point_total) == expected_total)
                    else flag_mismatch("point_total", expected_total, int'(point_total));
            end
        end
        prev_orders = orders;
        prev_times = order_times;
        prev_plates = check_spaces;
    end

    initial begin
        void'($urandom(50215));
        cycle_count = 0;
        serve_count = 0;
        miss_count = 0;
        reset = 1'b1;
        timer_go = 1'b0;
        check_spaces = '0;
        repeat (3) @(posedge clock);
        #1 reset = 1'b0;

        @(negedge clock);
        assert (orders == 4'b0000) else flag_mismatch("orders", 0, int'(orders));
        for (int i = 0; i < 4; i++) begin
            assert (order_times[i] == 5'd30)
                else flag_mismatch("order_times", 30, int'(order_times[i]));
        end
        assert (point_total == '0) else flag_mismatch("point_total", 0, int'(point_total));
        assert (!clear_space0 && !clear_space1)
            else abort_run("a clear output is high after reset");

        @(posedge clock);
        #1 timer_go = 1'b1;

        // burnt plates only, so the queue fills and the first orders expire at zero score
        check_spaces[0] = 4'b1100;
        check_spaces[1] = 4'b1101;
        repeat (1200) @(posedge clock);
        #1;

        repeat (150) begin
            pick_plates(3);
            repeat (16) @(posedge clock);
            #1;
        end

        // both windows ready at once, window 0 has to go first
        repeat (12) begin
            check_spaces = '0;
            while (model_recipes.size() < 2) @(posedge clock);
            #1 pick_plates(1);
            repeat (8) @(posedge clock);
            #1 pick_plates(1);
            repeat (8) @(posedge clock);
            #1;
        end

        // burnt again, so orders expire while the score can cover the penalty
        check_spaces[0] = 4'b1000;
        check_spaces[1] = 4'b1000;
        repeat (1100) @(posedge clock);
        #1 timer_go = 1'b0; // no more removals, the last outcome settles
        repeat (4) @(negedge clock);

        assert (int'(point_total) == expected_total)
            else flag_mismatch("point_total", expected_total, int'(point_total));
        assert (serve_count > 0) else abort_run("no order was served during the run");
        assert (miss_count > 0) else abort_run("no order expired during the run");
        $display("No errors");
        $finish;
    end

endmodule
